// ==== Makefile ====
# Verilator build and run for the low-frequency read path

VERILATOR ?= verilator
TOP       ?= lf_read_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line appears in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(BUILD_DIR)

// ==== list.f ====
source/lf_timing_pkg.sv
source/lf_cmd_pkg.sv
source/lf_phase_if.sv
source/carrier_phase_gen.sv
source/adc_serializer.sv
source/ssp_cmd_deserializer.sv
source/coil_drive_mixer.sv
source/lf_read_top.sv
verif/lf_read_tb.sv

// ==== source/adc_serializer.sv ====
// Captures one A/D sample per carrier period and shifts it out on the serial port with a frame pulse
`default_nettype none
`timescale 1ns/10ps

module adc_serializer (
    input  logic                   clk_lo,
    input  logic                   rst_n,
    lf_phase_if.consumer           ph,
    input  lf_timing_pkg::sample_t adc_d,
    output logic                   ssp_din,
    output logic                   ssp_frame
);
    import lf_timing_pkg::*;

    sample_t shift_q;

    // ------------------------------
    // sample shift register
    // ------------------------------

    // the A/D converts on the falling adc_clk edge, so by phase 0 the value is settled
    // and gets captured here, then walks out msb first over the next eight edges
    always_ff @(posedge clk_lo)
    begin
        if (ph.load_strobe)
            shift_q <= adc_d;
        else
            shift_q <= {shift_q[sample_bits-2:0], 1'b0};
    end

    // bit 7 appears during phase 1 and bit 0 during phase 0 of the next period
    assign ssp_din = shift_q[sample_bits-1];

    // ------------------------------
    // frame pulse
    // ------------------------------

    // the load cycle is one ahead of the frame cycle, so registering it
    // puts the pulse exactly on phase 1, lined up with bit 7 on ssp_din
    always_ff @(posedge clk_lo)
    begin
        if (!rst_n)
            ssp_frame <= 1'b0;
        else
            ssp_frame <= ph.load_strobe;
    end

    // one frame per carrier period, seven quiet cycles between pulses
    a_frame_period: assert property (
        @(posedge clk_lo) disable iff (!rst_n)
        ssp_frame |=> !ssp_frame [*7] ##1 ssp_frame
    ) else $error("ssp_frame is not high exactly one cycle in eight");

endmodule

`default_nettype wire

// ==== source/carrier_phase_gen.sv ====
// Divides clk_lo by eight and decodes the carrier and the per-period strobes for the read path
`default_nettype none
`timescale 1ns/10ps

module carrier_phase_gen (
    input  logic                clk_lo,
    input  logic                rst_n,
    lf_phase_if.producer        ph
);
    import lf_timing_pkg::*;

    phase_t phase_q;

    // ------------------------------
    // phase counter
    // ------------------------------

    // free running, the natural wrap from 7 to 0 gives the divide by eight
    always_ff @(posedge clk_lo)
    begin
        if (!rst_n)
            phase_q <= phase_load;
        else
            phase_q <= phase_q + 1'b1;
    end

    // decodes are straight off the counter so every consumer sees the same phase
    assign ph.phase        = phase_q;
    assign ph.carrier      = phase_q[phase_bits-1];
    assign ph.load_strobe  = (phase_q == phase_load);
    assign ph.frame_strobe = (phase_q == phase_frame);

    // the load cycle is always followed by the frame cycle and the two never overlap
    a_strobe_order: assert property (
        @(posedge clk_lo) disable iff (!rst_n)
        ph.load_strobe |-> !ph.frame_strobe ##1 (ph.frame_strobe && !ph.load_strobe)
    ) else $error("load and frame strobes overlap or are out of order");

endmodule

`default_nettype wire

// ==== source/coil_drive_mixer.sv ====
// Holds the accepted command and gates the carrier onto the coil drivers and output enables
`default_nettype none
`timescale 1ns/10ps

module coil_drive_mixer (
    input  logic                 clk_lo,
    input  logic                 rst_n,
    lf_phase_if.consumer         ph,
    input  logic                 cmd_valid,
    input  lf_cmd_pkg::lf_cmd_t  cmd,
    output logic                 pwr_lo,
    output logic                 pwr_hi,
    output logic [3:0]           pwr_oe,
    output logic                 adc_clk
);
    import lf_cmd_pkg::*;

    lf_cmd_t active_q;

    // ------------------------------
    // active command
    // ------------------------------

    // every accepted word replaces the previous one outright
    always_ff @(posedge clk_lo)
    begin
        if (!rst_n)
            active_q <= '0;
        else if (cmd_valid)
            active_q <= cmd;
    end

    // ------------------------------
    // coil outputs
    // ------------------------------

    // registered so the pins toggle cleanly on the clock edge,
    // which puts them one cycle behind the carrier
    always_ff @(posedge clk_lo)
    begin
        if (!rst_n)
        begin
            pwr_lo <= 1'b0;
            pwr_hi <= 1'b0;
            pwr_oe <= 4'b0000;
        end
        else
        begin
            pwr_lo <= ph.carrier & active_q.carrier_en;
            pwr_hi <= ph.carrier & active_q.hi_power_en;
            pwr_oe <= active_q.oe_en;
        end
    end

    // the A/D converts on the falling edge of adc_clk, which is the carrier rising,
    // leaving half a period to settle before the phase 0 capture
    assign adc_clk = ~ph.carrier;

    // both drivers only switch on together when the command in force asked for both
    a_driver_overlap: assert property (
        @(posedge clk_lo) disable iff (!rst_n)
        (pwr_hi && pwr_lo) |-> $past(active_q.hi_power_en && active_q.carrier_en)
    ) else $error("pwr_hi and pwr_lo high together without both enables");

endmodule

`default_nettype wire

// ==== source/lf_cmd_pkg.sv ====
// Command word layout for the serial return line, imported by the deserializer and the coil mixer
`default_nettype none

package lf_cmd_pkg;

    // one command word arrives per carrier period
    localparam int unsigned cmd_bits = 8;

    // width of the reserved field at the top of the word
    localparam int unsigned reserved_bits = 2;

    // the raw word as it comes off the shift register
    typedef logic [cmd_bits-1:0] cmd_word_t;

    // field view of the same word, most significant field first
    typedef struct packed {
        // must be zero, anything else marks the word as not for us
        logic [reserved_bits-1:0] reserved;
        // gates the carrier onto the high power driver
        logic                     hi_power_en;
        // gates the carrier onto the low power driver
        logic                     carrier_en;
        // bit 0 drives pwr_oe1, bit 3 drives pwr_oe4
        logic [3:0]               oe_en;
    } lf_cmd_t;

    // a word is only accepted when its reserved field is clear
    function automatic logic cmd_is_legal(input lf_cmd_t c);
        return c.reserved == '0;
    endfunction

endpackage

`default_nettype wire

// ==== source/lf_phase_if.sv ====
// Carrier phase bundle, driven by the phase generator and read by the serializer, deserializer and mixer
`default_nettype none
`timescale 1ns/10ps

interface lf_phase_if;
    import lf_timing_pkg::*;

    // current carrier phase, counts 0 to 7 and wraps
    phase_t phase;
    // the top phase bit, high for phases 4 to 7
    logic   carrier;
    // high while phase equals phase_load
    logic   load_strobe;
    // high while phase equals phase_frame
    logic   frame_strobe;

    // the phase generator owns every signal
    modport producer (output phase, carrier, load_strobe, frame_strobe);

    // everything else only listens
    modport consumer (input phase, carrier, load_strobe, frame_strobe);

endinterface

`default_nettype wire

// ==== source/lf_read_top.sv ====
// Top level of the low-frequency read path, wires the board pins to the phase, sample and coil blocks
`default_nettype none
`timescale 1ns/10ps

module lf_read_top (
    input  logic       clk_lo,
    input  logic       rst_n,
    input  logic [7:0] adc_d,
    input  logic       ssp_dout,
    output logic       adc_clk,
    output logic       ssp_clk,
    output logic       ssp_frame,
    output logic       ssp_din,
    output logic       pwr_lo,
    output logic       pwr_hi,
    output logic       pwr_oe1,
    output logic       pwr_oe2,
    output logic       pwr_oe3,
    output logic       pwr_oe4
);
    import lf_cmd_pkg::*;

    // command handoff from the deserializer to the mixer
    logic       cmd_valid;
    lf_cmd_t    cmd_word;
    logic [3:0] pwr_oe;

    // shared carrier phase bundle
    lf_phase_if ph_bus ();

    // ------------------------------
    // blocks
    // ------------------------------

    carrier_phase_gen u_phase (
        .clk_lo    (clk_lo),
        .rst_n     (rst_n),
        .ph        (ph_bus)
    );

    adc_serializer u_adc_ser (
        .clk_lo    (clk_lo),
        .rst_n     (rst_n),
        .ph        (ph_bus),
        .adc_d     (adc_d),
        .ssp_din   (ssp_din),
        .ssp_frame (ssp_frame)
    );

    ssp_cmd_deserializer u_cmd_des (
        .clk_lo    (clk_lo),
        .rst_n     (rst_n),
        .ph        (ph_bus),
        .ssp_dout  (ssp_dout),
        .cmd_valid (cmd_valid),
        .cmd       (cmd_word)
    );

    coil_drive_mixer u_coil (
        .clk_lo    (clk_lo),
        .rst_n     (rst_n),
        .ph        (ph_bus),
        .cmd_valid (cmd_valid),
        .cmd       (cmd_word),
        .pwr_lo    (pwr_lo),
        .pwr_hi    (pwr_hi),
        .pwr_oe    (pwr_oe),
        .adc_clk   (adc_clk)
    );

    // the serial port runs on the carrier-rate clock directly
    assign ssp_clk = clk_lo;

    // enable bit 0 goes to pwr_oe1
    assign pwr_oe1 = pwr_oe[0];
    assign pwr_oe2 = pwr_oe[1];
    assign pwr_oe3 = pwr_oe[2];
    assign pwr_oe4 = pwr_oe[3];

endmodule

`default_nettype wire

// ==== source/lf_timing_pkg.sv ====
// Carrier phase and A/D sample definitions, imported by every block that follows the carrier
`default_nettype none

package lf_timing_pkg;

    // ------------------------------
    // carrier phase
    // ------------------------------

    // three phase bits give eight clk_lo cycles per carrier period
    localparam int unsigned phase_bits = 3;

    // the phase counter itself, the top bit doubles as the carrier
    typedef logic [phase_bits-1:0] phase_t;

    // the A/D sample is captured on the edge where the phase reads zero
    localparam phase_t phase_load = phase_t'(0);

    // the serial frame pulse is high while the phase reads one
    localparam phase_t phase_frame = phase_t'(1);

    // ------------------------------
    // A/D sample
    // ------------------------------

    // the A/D converter delivers eight bits per conversion
    localparam int unsigned sample_bits = 8;

    typedef logic [sample_bits-1:0] sample_t;

endpackage

`default_nettype wire

// ==== source/ssp_cmd_deserializer.sv ====
// Collects the serial return line into command words and emits each legal word once per frame
`default_nettype none
`timescale 1ns/10ps

module ssp_cmd_deserializer (
    input  logic                 clk_lo,
    input  logic                 rst_n,
    lf_phase_if.consumer         ph,
    input  logic                 ssp_dout,
    output logic                 cmd_valid,
    output lf_cmd_pkg::lf_cmd_t  cmd
);
    import lf_cmd_pkg::*;

    cmd_word_t shift_q;
    cmd_word_t word_now;
    lf_cmd_t   word_cmd;
    logic      word_ok;

    // ------------------------------
    // input shift register
    // ------------------------------

    // ssp_dout is taken on every edge, first bit in ends up as the msb
    always_ff @(posedge clk_lo)
    begin
        shift_q <= word_now;
    end

    // the word includes the bit being sampled on the frame edge itself,
    // so the eight bits are those from phases 2 to 7, then 0, then 1
    assign word_now = {shift_q[cmd_bits-2:0], ssp_dout};
    assign word_cmd = lf_cmd_t'(word_now);
    assign word_ok  = cmd_is_legal(word_cmd);

    // ------------------------------
    // word check and output
    // ------------------------------

    // one strobe per frame at most, and only for words with a clear reserved field
    always_ff @(posedge clk_lo)
    begin
        if (!rst_n)
            cmd_valid <= 1'b0;
        else
            cmd_valid <= ph.frame_strobe && word_ok;
    end

    // the word is only meaningful while cmd_valid is high
    // rejected words leave the last good one in place
    always_ff @(posedge clk_lo)
    begin
        if (ph.frame_strobe && word_ok)
            cmd <= word_cmd;
    end

    // no back-pressure exists, a strobe longer than one cycle would double apply a word
    a_valid_single: assert property (
        @(posedge clk_lo) disable iff (!rst_n)
        cmd_valid |=> !cmd_valid
    ) else $error("cmd_valid held for more than one cycle");

endmodule

`default_nettype wire

// ==== verif/lf_read_tb.sv ====
// Self-checking testbench for the low-frequency read path, compiled with list.f and run as top
`default_nettype none
`timescale 1ns/10ps

module lf_read_tb;
    import lf_timing_pkg::*;
    import lf_cmd_pkg::*;

    // frames used by reset, framing, samples, commands, rejection and back to back in turn
    localparam int frames_total = 1 + 8 + 42 + 41 + 21 + 27;
    // one frame is eight cycles of 8 ns and the total is doubled for margin
    localparam int watchdog_ns = frames_total * 64 * 2;

    logic        clk_lo = 1'b0;
    logic        rst_n;
    logic [7:0]  adc_d;
    logic        ssp_dout;
    logic        adc_clk;
    logic        ssp_clk;
    logic        ssp_frame;
    logic        ssp_din;
    logic        pwr_lo;
    logic        pwr_hi;
    logic        pwr_oe1;
    logic        pwr_oe2;
    logic        pwr_oe3;
    logic        pwr_oe4;

    // reference state that steps on every rising edge
    phase_t      ph_m = '0;
    logic        ph_known = 1'b0;
    cmd_word_t   sh_m = '0;
    lf_cmd_t     word_in;
    logic        acc_v_m;
    lf_cmd_t     acc_m;
    lf_cmd_t     active_m;
    logic [5:0]  exp_coil;
    sample_t     cap_m;
    logic        cap_ok = 1'b0;
    int          n_checks = 0;
    int          n_errs = 0;
    logic [31:0] rng = 32'd31704;

    lf_read_top DUT (
        .clk_lo    (clk_lo),
        .rst_n     (rst_n),
        .adc_d     (adc_d),
        .ssp_dout  (ssp_dout),
        .adc_clk   (adc_clk),
        .ssp_clk   (ssp_clk),
        .ssp_frame (ssp_frame),
        .ssp_din   (ssp_din),
        .pwr_lo    (pwr_lo),
        .pwr_hi    (pwr_hi),
        .pwr_oe1   (pwr_oe1),
        .pwr_oe2   (pwr_oe2),
        .pwr_oe3   (pwr_oe3),
        .pwr_oe4   (pwr_oe4)
    );

    initial
    begin
        forever #4 clk_lo = ~clk_lo;
    end

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bit 7 shows in phase 1 and bit 0 in phase 0, so the index is minus the phase mod 8
    function automatic logic serial_ref(input sample_t s, input phase_t p);
        logic [2:0] idx;
        idx = 3'd0 - p;
        return s[idx];
    endfunction

    // coil pins as {pwr_lo, pwr_hi, oe4..oe1} for the carrier of the cycle before
    function automatic logic [5:0] coil_ref(input lf_cmd_t c, input logic car);
        return {car & c.carrier_en, car & c.hi_power_en, c.oe_en};
    endfunction

    // puts one word on ssp_dout msb first, so its last bit is taken on the frame edge
    task automatic send_word(input cmd_word_t w);
        cmd_word_t bits;
        bits = w;
        while (ph_m != 3'd2)
            @(negedge clk_lo);
        repeat (8)
        begin
            ssp_dout = bits[7];
            bits = bits << 1;
            @(negedge clk_lo);
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        $display("test %s finished with %0d errors", name, n_errs - start_errs);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    // the word as it stands with the bit being sampled on this edge
    assign word_in = {sh_m[6:0], ssp_dout};

    always @(posedge clk_lo)
    begin
        sh_m <= word_in;
        if (!rst_n)
        begin
            ph_m     <= '0;
            ph_known <= 1'b1;
            acc_v_m  <= 1'b0;
            active_m <= '0;
            exp_coil <= '0;
        end
        else
        begin
            ph_m <= ph_m + 3'd1;
            // a word with a clear reserved field is taken on the frame edge
            acc_v_m <= (ph_m == phase_frame) && (word_in.reserved == 2'b00);
            if ((ph_m == phase_frame) && (word_in.reserved == 2'b00))
                acc_m <= word_in;
            // then applied one edge later and seen on the pins one edge after that
            if (acc_v_m)
                active_m <= acc_m;
            exp_coil <= coil_ref(active_m, ph_m[phase_bits-1]);
            if (ph_m == phase_load)
            begin
                cap_m  <= adc_d;
                cap_ok <= 1'b1;
            end
        end
    end

    // outputs are all registered, so the falling edge sees them settled
    always @(negedge clk_lo)
    begin
        if (ph_known)
        begin
            n_checks = n_checks + 1;
            if (ssp_frame !== (ph_m == phase_frame))
            begin
                $display("ERR %0t ssp_frame is %b in phase %0d", $time, ssp_frame, ph_m);
                n_errs = n_errs + 1;
            end
            if (adc_clk !== ~ph_m[phase_bits-1])
            begin
                $display("ERR %0t adc_clk is %b in phase %0d", $time, adc_clk, ph_m);
                n_errs = n_errs + 1;
            end
            if (cap_ok && (ssp_din !== serial_ref(cap_m, ph_m)))
            begin
                $display("ERR %0t ssp_din is %b in phase %0d, sample %h",
                         $time, ssp_din, ph_m, cap_m);
                n_errs = n_errs + 1;
            end
            if ({pwr_lo, pwr_hi, pwr_oe4, pwr_oe3, pwr_oe2, pwr_oe1} !== exp_coil)
            begin
                $display("ERR %0t coil pins %b, expected %b", $time,
                         {pwr_lo, pwr_hi, pwr_oe4, pwr_oe3, pwr_oe2, pwr_oe1}, exp_coil);
                n_errs = n_errs + 1;
            end
        end
    end

    // ssp_clk follows clk_lo, so it is looked at midway through each half cycle
    always @(clk_lo)
    begin
        #2;
        n_checks = n_checks + 1;
        if (ssp_clk !== clk_lo)
        begin
            $display("ERR %0t ssp_clk is %b while clk_lo is %b", $time, ssp_clk, clk_lo);
            n_errs = n_errs + 1;
        end
    end

    // ------------------------------
    // tests
    // ------------------------------

    initial
    begin
        int        t_errs;
        int        frames_seen;
        int        car_seen;
        cmd_word_t w;
        lf_cmd_t   last_ok;

        rst_n    = 1'b0;
        adc_d    = '0;
        ssp_dout = 1'b0;

        // the model checks every edge through reset and just after it
        t_errs = n_errs;
        repeat (4) @(posedge clk_lo);
        @(negedge clk_lo);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_lo);
        report_test("reset state", t_errs);

        // 64 cycles hold exactly eight frames and 32 carrier-high cycles
        t_errs = n_errs;
        frames_seen = 0;
        car_seen = 0;
        repeat (64)
        begin
            @(negedge clk_lo);
            if (ssp_frame)
                frames_seen = frames_seen + 1;
            if (!adc_clk)
                car_seen = car_seen + 1;
        end
        if (frames_seen != 8)
        begin
            $display("ERR %0t %0d frame pulses in 64 cycles", $time, frames_seen);
            n_errs = n_errs + 1;
        end
        if (car_seen != 32)
        begin
            $display("ERR %0t carrier high for %0d of 64 cycles", $time, car_seen);
            n_errs = n_errs + 1;
        end
        report_test("framing and carrier", t_errs);

        // each new sample lands mid period and well clear of the phase 0 capture
        t_errs = n_errs;
        repeat (40)
        begin
            while (ph_m != 3'd4)
                @(negedge clk_lo);
            rng = xorshift32(rng);
            adc_d = rng[7:0];
            @(negedge clk_lo);
        end
        repeat (16) @(negedge clk_lo);
        report_test("sample serialization", t_errs);

        // each command is followed by a rejected word, so it holds for a full period
        t_errs = n_errs;
        repeat (20)
        begin
            rng = xorshift32(rng);
            send_word({2'b00, rng[5:0]});
            send_word(8'hFF);
        end
        report_test("command acceptance", t_errs);

        t_errs = n_errs;
        repeat (4)
        begin
            rng = xorshift32(rng);
            last_ok = {2'b00, rng[5:0]};
            send_word(last_ok);
            repeat (3)
            begin
                rng = xorshift32(rng);
                w = rng[7:0];
                if (w[7:6] == 2'b00)
                    w[7:6] = 2'b10;
                send_word(w);
            end
            // in phase 5 the pins show the carrier of phase 4, which is high
            repeat (3) @(negedge clk_lo);
            if ({pwr_lo, pwr_hi, pwr_oe4, pwr_oe3, pwr_oe2, pwr_oe1} !==
                {last_ok.carrier_en, last_ok.hi_power_en, last_ok.oe_en})
            begin
                $display("ERR %0t rejected word changed the coil pins", $time);
                n_errs = n_errs + 1;
            end
        end
        report_test("command rejection", t_errs);

        t_errs = n_errs;
        repeat (24)
        begin
            rng = xorshift32(rng);
            send_word({2'b00, rng[5:0]});
        end
        send_word(8'hFF);
        repeat (8) @(negedge clk_lo);
        report_test("back to back replacement", t_errs);

        $display("%0d checks, %0d errors", n_checks, n_errs);
        if (n_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // ends a run that stalls well past the length of all tests
    initial
    begin
        #(watchdog_ns);
        $display("the run timed out after %0d ns before all tests finished", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
